// ==== cpu_frontend.f ====
common/rv32i_pkg.sv
common/fetch_pkg.sv
fetch/line_fill.sv
fetch/fetch_unit.sv
design/instr_queue.sv
design/decode_stage.sv
design/cpu_frontend.sv
testbench/tb_cpu_frontend.sv

// ==== Bender.yml ====
package:
  name: cpu_frontend

sources:
  - common/rv32i_pkg.sv
  - common/fetch_pkg.sv
  - fetch/line_fill.sv
  - fetch/fetch_unit.sv
  - design/instr_queue.sv
  - design/decode_stage.sv
  - design/cpu_frontend.sv
  - target: simulation
    files:
      - testbench/tb_cpu_frontend.sv

// ==== testbench/tb_cpu_frontend.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_cpu_frontend
import rv32i_pkg::*;
import fetch_pkg::*;
();

    localparam logic [31:0] RESET_PC      = 32'haaaaa000;
    localparam int          IQ_DEPTH      = 16;
    localparam int          NUM_CREDITS   = 4;
    localparam int          CLK_PERIOD    = 20;
    localparam int          RESET_CYCLES  = 8;
    localparam int          NUM_INSTR     = 400;
    localparam int          STARVE_AT     = 150;
    localparam int          STARVE_CYCLES = 300;
    localparam logic [31:0] SEED          = 32'h6a76;
    localparam longint      WATCHDOG_NS   = longint'(NUM_INSTR) * 40 * CLK_PERIOD;

    logic                 clk;
    logic                 rst;
    logic [31:0]          bmem_addr;
    logic                 bmem_read;
    logic                 bmem_ready;
    logic [BEAT_BITS-1:0] bmem_rdata;
    logic                 bmem_rvalid;
    decoded_t             decoded;
    logic                 credit;

    int unsigned          errors;
    int unsigned          requests;
    int unsigned          checked;
    logic [31:0]          next_line;

    cpu_frontend #(
        .RESET_PC      (RESET_PC),
        .IQ_DEPTH      (IQ_DEPTH),
        .NUM_CREDITS   (NUM_CREDITS)
    ) i_dut (
        .clk           (clk),
        .rst           (rst),
        .bmem_addr_o   (bmem_addr),
        .bmem_read_o   (bmem_read),
        .bmem_ready_i  (bmem_ready),
        .bmem_rdata_i  (bmem_rdata),
        .bmem_rvalid_i (bmem_rvalid),
        .decoded_o     (decoded),
        .credit_i      (credit)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // 9 legal opcodes, 7 that decode must reject
    function automatic logic [6:0] opcode_pick(input logic [3:0] idx);
        case (idx)
            4'd0:    return 7'b0110111;
            4'd1:    return 7'b0010111;
            4'd2:    return 7'b0010011;
            4'd3:    return 7'b0110011;
            4'd4:    return 7'b1100011;
            4'd5:    return 7'b1101111;
            4'd6:    return 7'b1100111;
            4'd7:    return 7'b0000011;
            4'd8:    return 7'b0100011;
            4'd9:    return 7'b0001111;
            4'd10:   return 7'b1110011;
            4'd11:   return 7'b0000000;
            4'd12:   return 7'b1111111;
            4'd13:   return 7'b0101111;
            4'd14:   return 7'b1010011;
            default: return 7'b0011011;
        endcase
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] h;
        h = addr ^ 32'h5bd1e995;
        h = h * 32'h9e3779b1;
        h = h ^ (h >> 15);
        h = h * 32'h85ebca6b;
        h = h ^ (h >> 13);
        return {h[31:7], opcode_pick(h[3:0])};
    endfunction

    function automatic op_class_e class_of(input logic [6:0] opcode);
        case (opcode)
            7'b0110111, 7'b0010111, 7'b0010011, 7'b0110011: return alu;
            7'b1100011, 7'b1101111, 7'b1100111:             return br;
            7'b0000011, 7'b0100011:                         return mem;
            default:                                        return none;
        endcase
    endfunction

    function automatic decoded_t expect_decoded(input int unsigned k);
        decoded_t d;
        d          = '0;
        d.valid    = 1'b1;
        d.order    = 64'(k);
        d.pc       = RESET_PC + 32'(4 * k);
        d.inst     = mem_word(d.pc);
        d.op_class = class_of(d.inst[6:0]);
        d.rd_addr  = d.inst[11:7];
        d.rs1_addr = d.inst[19:15];
        d.rs2_addr = d.inst[24:20];
        return d;
    endfunction

    // 32-byte lines touched by the first n words from reset
    function automatic int unsigned lines_spanned(input int unsigned n);
        return ((RESET_PC + 32'(4 * (n - 1))) >> OFFSET_BITS)
             - (RESET_PC >> OFFSET_BITS) + 1;
    endfunction

    task automatic check_equal(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
            $display("** FAIL **");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        errors++;
        $display("ERROR at %0t ns: %s", $time, why);
        $display("** FAIL **");
        $fatal(1, "run aborted");
    endtask

    task automatic compare_output(input decoded_t got, input int unsigned k);
        decoded_t exp;
        exp = expect_decoded(k);
        check_equal(got.order, exp.order, "order");
        check_equal(got.pc, exp.pc, "pc");
        check_equal(got.inst, exp.inst, "inst");
        check_equal(got.op_class, exp.op_class, "op_class");
        check_equal(got.rd_addr, exp.rd_addr, "rd_addr");
        check_equal(got.rs1_addr, exp.rs1_addr, "rs1_addr");
        check_equal(got.rs2_addr, exp.rs2_addr, "rs2_addr");
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // burst memory, random ready and beat gaps
    initial begin : bus_model
        logic [31:0] bus_rng;
        logic [31:0] burst_addr;
        int          beat;
        bus_rng    = SEED;
        burst_addr = '0;
        beat       = BEATS_PER_LINE;
        forever begin
            @(negedge clk);
            bus_rng     = lcg_next(bus_rng);
            bmem_rvalid = 1'b0;
            bmem_ready  = 1'b0;
            if (rst) begin
                beat = BEATS_PER_LINE;
            end else if (beat < BEATS_PER_LINE) begin
                if (bus_rng[25:24] != 2'b00) begin
                    bmem_rvalid = 1'b1;
                    bmem_rdata  = {mem_word(burst_addr + 32'(8 * beat) + 32'd4),
                                   mem_word(burst_addr + 32'(8 * beat))};
                    beat++;
                end
            end else begin
                bmem_ready = (bus_rng[27:26] != 2'b00);
                if (bmem_ready && bmem_read) begin // taken at next rising edge
                    check_equal(bmem_addr, next_line, "bus request address");
                    burst_addr = bmem_addr;
                    next_line  = next_line + 32'd32;
                    requests++;
                    beat = 0;
                end
            end
        end
    end

    // downstream consumer, returns credits late
    initial begin : consumer
        logic [31:0] credit_rng;
        int          outstanding;
        int          starve_left;
        credit_rng  = lcg_next(SEED);
        outstanding = 0;
        starve_left = 0;
        forever begin
            @(negedge clk);
            credit_rng = lcg_next(credit_rng);
            if (credit) outstanding--; // sampled at the last rising edge
            credit = 1'b0;
            if (!rst && decoded.valid) begin
                if (requests == 0) abort_run("decoded output before any bus request");
                compare_output(decoded, checked);
                outstanding++;
                if (outstanding > NUM_CREDITS) abort_run("more outputs than credits allow");
                checked++;
                if (checked == STARVE_AT) starve_left = STARVE_CYCLES;
            end
            if (starve_left > 0) begin
                starve_left--;
            end else if (outstanding > 0 && credit_rng[24]) begin
                credit = 1'b1;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        abort_run("watchdog timeout, decoded outputs stopped arriving");
    end

    initial begin : main
        int unsigned min_lines;
        int unsigned max_lines;
        rst         = 1'b1;
        credit      = 1'b0;
        bmem_ready  = 1'b0;
        bmem_rvalid = 1'b0;
        bmem_rdata  = '0;
        errors      = 0;
        requests    = 0;
        checked     = 0;
        next_line   = RESET_PC & ~32'd31;

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_equal(bmem_read, 1'b0, "bus read in reset");
            check_equal(decoded.valid, 1'b0, "decoded valid in reset");
        end
        rst = 1'b0;

        while (checked < NUM_INSTR) @(negedge clk);

        // fetch runs ahead of decode by at most a full queue and one dequeue
        min_lines = lines_spanned(NUM_INSTR);
        max_lines = lines_spanned(NUM_INSTR + IQ_DEPTH + 2);
        if (requests < min_lines) abort_run("fewer bus requests than lines covered");
        if (requests > max_lines) abort_run("more bus requests than lines fetched");

        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/cpu_frontend.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_frontend
import rv32i_pkg::*;
import fetch_pkg::*;
#(
    parameter logic [31:0] RESET_PC    = 32'haaaaa000,
    parameter int          IQ_DEPTH    = 16,
    parameter int          NUM_CREDITS = 4
) (
    input  wire logic                 clk,
    input  wire logic                 rst,

    output logic [31:0]               bmem_addr_o,
    output logic                      bmem_read_o,
    input  wire logic                 bmem_ready_i,
    input  wire logic [BEAT_BITS-1:0] bmem_rdata_i,
    input  wire logic                 bmem_rvalid_i,

    output decoded_t                  decoded_o,
    input  wire logic                 credit_i
);

    logic                 miss_req;
    logic [31:0]          miss_addr;
    logic                 fill_done;
    logic [LINE_BITS-1:0] fill_line;

    logic                 iq_full;
    logic                 iq_empty;
    logic                 enq;
    logic                 deq;
    fetch_entry_t         enq_entry;
    fetch_entry_t         head_entry;

    fetch_unit #(
        .RESET_PC    (RESET_PC)
    ) i_fetch_unit (
        .clk         (clk),
        .rst         (rst),
        .miss_req_o  (miss_req),
        .miss_addr_o (miss_addr),
        .fill_done_i (fill_done),
        .fill_line_i (fill_line),
        .iq_full_i   (iq_full),
        .enq_o       (enq),
        .entry_o     (enq_entry)
    );

    line_fill i_line_fill (
        .clk           (clk),
        .rst           (rst),
        .miss_req_i    (miss_req),
        .miss_addr_i   (miss_addr),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i),
        .fill_done_o   (fill_done),
        .fill_line_o   (fill_line)
    );

    instr_queue #(
        .IQ_DEPTH (IQ_DEPTH)
    ) i_instr_queue (
        .clk      (clk),
        .rst      (rst),
        .enq_i    (enq),
        .entry_i  (enq_entry),
        .full_o   (iq_full),
        .deq_i    (deq),
        .entry_o  (head_entry),
        .empty_o  (iq_empty)
    );

    decode_stage #(
        .NUM_CREDITS (NUM_CREDITS)
    ) i_decode_stage (
        .clk         (clk),
        .rst         (rst),
        .iq_empty_i  (iq_empty),
        .iq_entry_i  (head_entry),
        .deq_o       (deq),
        .credit_i    (credit_i),
        .decoded_o   (decoded_o)
    );

endmodule

`default_nettype wire

// ==== design/decode_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module decode_stage
import rv32i_pkg::*;
import fetch_pkg::*;
#(
    parameter int NUM_CREDITS = 4
) (
    input  wire logic         clk,
    input  wire logic         rst,

    input  wire logic         iq_empty_i,
    input  wire fetch_entry_t iq_entry_i,
    output logic              deq_o,

    // rename side
    input  wire logic         credit_i,
    output decoded_t          decoded_o
);

    localparam int CNT_BITS = $clog2(NUM_CREDITS + 1);

    logic [CNT_BITS-1:0] credits_q;
    logic                valid_q;
    decoded_t            dec_d;
    decoded_t            dec_q;

    assign deq_o = !iq_empty_i && (credits_q != '0);

    always_comb begin
        dec_d          = '0;
        dec_d.valid    = deq_o;
        dec_d.order    = iq_entry_i.order;
        dec_d.pc       = iq_entry_i.pc;
        dec_d.inst     = iq_entry_i.inst;
        dec_d.op_class = classify(iq_entry_i.inst[6:0]);
        dec_d.rd_addr  = iq_entry_i.inst[11:7];
        dec_d.rs1_addr = iq_entry_i.inst[19:15];
        dec_d.rs2_addr = iq_entry_i.inst[24:20];
    end

    // one credit per dequeue, one back per credit pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            credits_q <= CNT_BITS'(NUM_CREDITS);
            valid_q   <= 1'b0;
        end else begin
            valid_q <= deq_o;
            if (deq_o && !credit_i) begin
                credits_q <= credits_q - 1'b1;
            end else if (!deq_o && credit_i) begin
                credits_q <= credits_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (deq_o) dec_q <= dec_d;
    end

    always_comb begin
        decoded_o       = dec_q;
        decoded_o.valid = valid_q;
    end

    // consumer must not return more than it was given
    a_credit_bound: assert property (
        @(posedge clk) disable iff (rst) credits_q <= CNT_BITS'(NUM_CREDITS)
    ) else $error("credit counter above limit");

endmodule

`default_nettype wire

// ==== design/instr_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

module instr_queue
import fetch_pkg::*;
#(
    parameter int IQ_DEPTH = 16
) (
    input  wire logic         clk,
    input  wire logic         rst,

    input  wire logic         enq_i,
    input  wire fetch_entry_t entry_i,
    output logic              full_o,

    input  wire logic         deq_i,
    output fetch_entry_t      entry_o,
    output logic              empty_o
);

    localparam int PTR_BITS = $clog2(IQ_DEPTH);

    fetch_entry_t        mem_q [IQ_DEPTH];

    // msb is the wrap bit
    logic [PTR_BITS:0]   wr_ptr_q;
    logic [PTR_BITS:0]   rd_ptr_q;

    assign empty_o = (wr_ptr_q == rd_ptr_q);
    assign full_o  = (wr_ptr_q[PTR_BITS] != rd_ptr_q[PTR_BITS])
                  && (wr_ptr_q[PTR_BITS-1:0] == rd_ptr_q[PTR_BITS-1:0]);

    assign entry_o = mem_q[rd_ptr_q[PTR_BITS-1:0]]; // head, no read latency

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (enq_i) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (deq_i) rd_ptr_q <= rd_ptr_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (enq_i) mem_q[wr_ptr_q[PTR_BITS-1:0]] <= entry_i;
    end

    a_no_overflow: assert property (
        @(posedge clk) disable iff (rst) enq_i |-> !full_o
    ) else $error("enqueue into full queue");

    a_no_underflow: assert property (
        @(posedge clk) disable iff (rst) deq_i |-> !empty_o
    ) else $error("dequeue from empty queue");

endmodule

`default_nettype wire

// ==== fetch/fetch_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_unit
import fetch_pkg::*;
#(
    parameter logic [31:0] RESET_PC = 32'haaaaa000
) (
    input  wire logic                 clk,
    input  wire logic                 rst,

    // line fill side
    output logic                      miss_req_o,
    output logic [31:0]               miss_addr_o,
    input  wire logic                 fill_done_i,
    input  wire logic [LINE_BITS-1:0] fill_line_i,

    // queue side
    input  wire logic                 iq_full_i,
    output logic                      enq_o,
    output fetch_entry_t              entry_o
);

    localparam int TAG_BITS = 32 - OFFSET_BITS;
    localparam int SEL_BITS = $clog2(WORDS_PER_LINE);

    logic [31:0]          pc_q;
    logic [63:0]          order_q;

    // one-line buffer
    logic [LINE_BITS-1:0] line_q;
    logic [TAG_BITS-1:0]  tag_q;
    logic                 line_valid_q;

    logic                 hit;
    logic [SEL_BITS-1:0]  word_sel;
    logic [31:0]          word;

    assign hit      = line_valid_q && (tag_q == pc_q[31:OFFSET_BITS]);
    assign word_sel = pc_q[OFFSET_BITS-1:2];
    assign word     = line_q[word_sel*32 +: 32];

    // miss stays up until the buffer holds the pc's line
    assign miss_req_o  = !hit;
    assign miss_addr_o = {pc_q[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

    assign enq_o = hit && !iq_full_i;

    always_comb begin
        entry_o       = '0;
        entry_o.order = order_q;
        entry_o.pc    = pc_q;
        entry_o.inst  = word;
    end

    // pc and order advance only with a write
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q    <= RESET_PC;
            order_q <= '0;
        end else if (enq_o) begin
            pc_q    <= pc_q + 32'd4;
            order_q <= order_q + 64'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            line_valid_q <= 1'b0;
        end else if (fill_done_i) begin
            line_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_done_i) begin
            line_q <= fill_line_i;
            tag_q  <= miss_addr_o[31:OFFSET_BITS]; // pc holds still during a miss
        end
    end

    // a fill only answers a pending miss
    a_fill_on_miss: assert property (
        @(posedge clk) disable iff (rst) fill_done_i |-> miss_req_o
    ) else $error("line fill done with no miss pending");

endmodule

`default_nettype wire

// ==== fetch/line_fill.sv ====
`timescale 1ns/100ps
`default_nettype none

module line_fill
import fetch_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 rst,

    input  wire logic                 miss_req_i,
    input  wire logic [31:0]          miss_addr_i,

    // burst read bus
    output logic [31:0]               bmem_addr_o,
    output logic                      bmem_read_o,
    input  wire logic                 bmem_ready_i,
    input  wire logic [BEAT_BITS-1:0] bmem_rdata_i,
    input  wire logic                 bmem_rvalid_i,

    output logic                      fill_done_o,
    output logic [LINE_BITS-1:0]      fill_line_o
);

    localparam int CNT_BITS = $clog2(BEATS_PER_LINE);

    typedef enum logic [1:0] {
        st_idle,
        st_request,
        st_collect,
        st_done
    } fill_state_e;

    fill_state_e          state_q;
    logic [CNT_BITS-1:0]  beat_q;
    logic [31:0]          addr_q;
    logic [LINE_BITS-1:0] line_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= st_idle;
            beat_q  <= '0;
        end else begin
            case (state_q)
                st_idle: begin
                    if (miss_req_i) state_q <= st_request;
                end
                st_request: begin
                    if (bmem_ready_i) begin // accepted
                        state_q <= st_collect;
                        beat_q  <= '0;
                    end
                end
                st_collect: begin
                    if (bmem_rvalid_i) begin
                        beat_q <= beat_q + 1'b1;
                        if (beat_q == CNT_BITS'(BEATS_PER_LINE - 1)) state_q <= st_done;
                    end
                end
                default: state_q <= st_idle; // st_done lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == st_idle && miss_req_i) addr_q <= miss_addr_i;
        if (state_q == st_collect && bmem_rvalid_i) begin
            line_q[beat_q*BEAT_BITS +: BEAT_BITS] <= bmem_rdata_i; // lowest beat first
        end
    end

    assign bmem_addr_o = addr_q;
    assign bmem_read_o = (state_q == st_request);
    assign fill_done_o = (state_q == st_done);
    assign fill_line_o = line_q;

    // memory only answers an accepted burst
    a_no_beat_in_idle: assert property (
        @(posedge clk) disable iff (rst) bmem_rvalid_i |-> state_q != st_idle
    ) else $error("read beat with no burst outstanding");

endmodule

`default_nettype wire

// ==== common/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    // bus and line geometry
    localparam int LINE_BITS      = 256;
    localparam int BEAT_BITS      = 64;
    localparam int BEATS_PER_LINE = LINE_BITS / BEAT_BITS;
    localparam int WORDS_PER_LINE = LINE_BITS / 32;

    // byte offset inside a line
    localparam int OFFSET_BITS    = $clog2(LINE_BITS / 8);

    // queue payload, fetch to decode
    typedef struct packed {
        logic [63:0] order;
        logic [31:0] pc;
        logic [31:0] inst;
    } fetch_entry_t;

endpackage

`default_nettype wire

// ==== common/rv32i_pkg.sv ====
`default_nettype none

package rv32i_pkg;

    // base opcodes, inst[6:0]
    typedef enum logic [6:0] {
        op_b_lui   = 7'b0110111,
        op_b_auipc = 7'b0010111,
        op_b_imm   = 7'b0010011,
        op_b_reg   = 7'b0110011,
        op_b_br    = 7'b1100011,
        op_b_jal   = 7'b1101111,
        op_b_jalr  = 7'b1100111,
        op_b_load  = 7'b0000011,
        op_b_store = 7'b0100011
    } opcode_e;

    typedef enum logic [1:0] {
        alu  = 2'b00,
        br   = 2'b01,
        mem  = 2'b10,
        none = 2'b11
    } op_class_e;

    typedef struct packed {
        logic        valid;
        logic [63:0] order;
        logic [31:0] pc;
        logic [31:0] inst;
        op_class_e   op_class;
        logic [4:0]  rd_addr;
        logic [4:0]  rs1_addr;
        logic [4:0]  rs2_addr;
    } decoded_t;

    function automatic op_class_e classify(input logic [6:0] opcode);
        case (opcode)
            op_b_lui, op_b_auipc, op_b_imm, op_b_reg: return alu;
            op_b_br, op_b_jal, op_b_jalr:             return br;
            op_b_load, op_b_store:                    return mem;
            default:                                  return none; // unknown opcode
        endcase
    endfunction

endpackage

`default_nettype wire
